// File: hw/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

   ////////////////////
   // Field types
   ////////////////////

   typedef logic [31:0] instr_t;
   typedef logic [5:0]  opcode_t;   // Instruction bits 31:26
   typedef logic [5:0]  funct_t;    // Instruction bits 5:0

   // Bit 2 signed, bits 1:0 size (0 none, 1 byte, 2 half, 3 word)
   typedef logic [2:0]  mem_sel_t;

   ////////////////////
   // ALU encodings
   ////////////////////

   typedef enum logic [1:0]
   {
      ALU_OP_MEM   = 2'd0,   // Loads, stores, LUI
      ALU_OP_JUMP  = 2'd1,   // Branches and jumps
      ALU_OP_ARITH = 2'd2    // R-type and immediate ALU ops
   } alu_op_e;

   typedef enum logic [3:0]
   {
      ALU_CTRL_AND  = 4'd0,
      ALU_CTRL_OR   = 4'd1,
      ALU_CTRL_ADD  = 4'd2,
      ALU_CTRL_SUB  = 4'd6,
      ALU_CTRL_SLT  = 4'd7,
      ALU_CTRL_LUI  = 4'd8,
      ALU_CTRL_XOR  = 4'd9,
      ALU_CTRL_NOR  = 4'd10,
      ALU_CTRL_SLL  = 4'd11,
      ALU_CTRL_SRL  = 4'd12,
      ALU_CTRL_SRA  = 4'd13,
      ALU_CTRL_JUMP = 4'd14
   } alu_ctrl_e;

   ////////////////////
   // Datapath control word
   ////////////////////

   typedef struct packed
   {
      logic     reg_dst;      // Write rd instead of rt
      logic     reg_write;
      logic     alu_src;      // Second operand from immediate
      logic     mem_read;
      logic     mem_write;
      logic     mem_to_reg;   // Writeback from data memory
      mem_sel_t mem_sel;
   } ctrl_word_t;

   // Opcodes
   localparam opcode_t OP_SPECIAL = 6'd0;
   localparam opcode_t OP_J       = 6'd2;
   localparam opcode_t OP_JAL     = 6'd3;
   localparam opcode_t OP_BEQ     = 6'd4;
   localparam opcode_t OP_BNE     = 6'd5;
   localparam opcode_t OP_ADDI    = 6'd8;
   localparam opcode_t OP_SLTI    = 6'd10;
   localparam opcode_t OP_ANDI    = 6'd12;
   localparam opcode_t OP_ORI     = 6'd13;
   localparam opcode_t OP_XORI    = 6'd14;
   localparam opcode_t OP_LUI     = 6'd15;
   localparam opcode_t OP_LB      = 6'd32;
   localparam opcode_t OP_LH      = 6'd33;
   localparam opcode_t OP_LW      = 6'd35;
   localparam opcode_t OP_LBU     = 6'd36;
   localparam opcode_t OP_LHU     = 6'd37;
   localparam opcode_t OP_LWU     = 6'd39;
   localparam opcode_t OP_SB      = 6'd40;
   localparam opcode_t OP_SH      = 6'd41;
   localparam opcode_t OP_SW      = 6'd43;

   // Funct codes under OP_SPECIAL
   localparam funct_t FN_SLL  = 6'd0;
   localparam funct_t FN_SRL  = 6'd2;
   localparam funct_t FN_SRA  = 6'd3;
   localparam funct_t FN_SLLV = 6'd4;
   localparam funct_t FN_SRLV = 6'd6;
   localparam funct_t FN_SRAV = 6'd7;
   localparam funct_t FN_JR   = 6'd8;
   localparam funct_t FN_JALR = 6'd9;
   localparam funct_t FN_ADDU = 6'd33;
   localparam funct_t FN_SUBU = 6'd35;
   localparam funct_t FN_AND  = 6'd36;
   localparam funct_t FN_OR   = 6'd37;
   localparam funct_t FN_XOR  = 6'd38;
   localparam funct_t FN_NOR  = 6'd39;
   localparam funct_t FN_SLT  = 6'd42;

endpackage

`default_nettype wire

// File: hw/main_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module main_decoder
(
   input  wire mips_ctrl_pkg::instr_t i_instruction,
   output mips_ctrl_pkg::ctrl_word_t  o_ctrl,
   output mips_ctrl_pkg::alu_op_e     o_alu_op
);

   import mips_ctrl_pkg::*;

   opcode_t opcode;
   funct_t  funct;

   assign opcode = i_instruction[31:26];
   assign funct  = i_instruction[5:0];

   function automatic ctrl_word_t load_word(input mem_sel_t sel);
      ctrl_word_t w;
      w            = '0;
      w.reg_write  = 1'b1;
      w.alu_src    = 1'b1;
      w.mem_read   = 1'b1;
      w.mem_to_reg = 1'b1;
      w.mem_sel    = sel;
      return w;
   endfunction

   function automatic ctrl_word_t store_word(input mem_sel_t sel);
      ctrl_word_t w;
      w           = '0;
      w.alu_src   = 1'b1;
      w.mem_write = 1'b1;
      w.mem_sel   = sel;
      return w;
   endfunction

   always_comb
   begin
      o_ctrl   = '0;           // Unknown encodings stay all zero
      o_alu_op = ALU_OP_MEM;
      if (opcode == OP_SPECIAL)
      begin
         case (funct)
            FN_SLL, FN_SRL, FN_SRA:
            begin
               o_ctrl.reg_dst   = 1'b1;
               o_ctrl.reg_write = 1'b1;
               o_ctrl.alu_src   = 1'b1;   // Shift amount from shamt
               o_alu_op         = ALU_OP_ARITH;
            end
            FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU, FN_SUBU,
            FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT:
            begin
               o_ctrl.reg_dst   = 1'b1;
               o_ctrl.reg_write = 1'b1;
               o_alu_op         = ALU_OP_ARITH;
            end
            FN_JR:
               o_alu_op = ALU_OP_JUMP;    // No writeback
            FN_JALR:
            begin
               o_ctrl.reg_dst   = 1'b1;
               o_ctrl.reg_write = 1'b1;
               o_alu_op         = ALU_OP_JUMP;
            end
            default: ;
         endcase
      end
      else
      begin
         case (opcode)
            OP_LB:  o_ctrl = load_word(3'd5);
            OP_LH:  o_ctrl = load_word(3'd6);
            OP_LW:  o_ctrl = load_word(3'd7);
            OP_LWU: o_ctrl = load_word(3'd3);
            OP_LBU: o_ctrl = load_word(3'd1);
            OP_LHU: o_ctrl = load_word(3'd2);
            OP_SB:  o_ctrl = store_word(3'd1);
            OP_SH:  o_ctrl = store_word(3'd2);
            OP_SW:  o_ctrl = store_word(3'd3);
            OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_LUI:
            begin
               o_ctrl.reg_write = 1'b1;
               o_ctrl.alu_src   = 1'b1;
               o_alu_op = (opcode == OP_LUI) ? ALU_OP_MEM : ALU_OP_ARITH;
            end
            OP_BEQ, OP_BNE:
            begin
               o_ctrl.alu_src = 1'b1;
               o_alu_op       = ALU_OP_JUMP;
            end
            OP_J:
               o_alu_op = ALU_OP_JUMP;
            OP_JAL:
            begin
               o_ctrl.reg_dst   = 1'b1;
               o_ctrl.reg_write = 1'b1;   // Link register
               o_alu_op         = ALU_OP_JUMP;
            end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/alu_control.sv
`timescale 1ns/1ns
`default_nettype none

module alu_control
(
   input  wire mips_ctrl_pkg::alu_op_e i_alu_op,
   input  wire mips_ctrl_pkg::instr_t  i_instruction,
   output mips_ctrl_pkg::alu_ctrl_e    o_alu_ctrl
);

   import mips_ctrl_pkg::*;

   opcode_t opcode;
   funct_t  funct;

   assign opcode = i_instruction[31:26];
   assign funct  = i_instruction[5:0];

   // Class comes from the register, opcode and funct from the live instruction
   always_comb
   begin
      case (i_alu_op)
         ALU_OP_MEM:
            o_alu_ctrl = (opcode == OP_LUI) ? ALU_CTRL_LUI : ALU_CTRL_ADD;
         ALU_OP_JUMP:
            o_alu_ctrl = ALU_CTRL_JUMP;
         ALU_OP_ARITH:
         begin
            if (opcode == OP_SPECIAL)
            begin
               case (funct)
                  FN_SLL, FN_SLLV: o_alu_ctrl = ALU_CTRL_SLL;
                  FN_SRL, FN_SRLV: o_alu_ctrl = ALU_CTRL_SRL;
                  FN_SRA, FN_SRAV: o_alu_ctrl = ALU_CTRL_SRA;
                  FN_ADDU:         o_alu_ctrl = ALU_CTRL_ADD;
                  FN_SUBU:         o_alu_ctrl = ALU_CTRL_SUB;
                  FN_AND:          o_alu_ctrl = ALU_CTRL_AND;
                  FN_OR:           o_alu_ctrl = ALU_CTRL_OR;
                  FN_XOR:          o_alu_ctrl = ALU_CTRL_XOR;
                  FN_NOR:          o_alu_ctrl = ALU_CTRL_NOR;
                  FN_SLT:          o_alu_ctrl = ALU_CTRL_SLT;
                  default:         o_alu_ctrl = ALU_CTRL_ADD;
               endcase
            end
            else
            begin
               case (opcode)
                  OP_ADDI: o_alu_ctrl = ALU_CTRL_ADD;
                  OP_ANDI: o_alu_ctrl = ALU_CTRL_AND;
                  OP_ORI:  o_alu_ctrl = ALU_CTRL_OR;
                  OP_XORI: o_alu_ctrl = ALU_CTRL_XOR;
                  OP_SLTI: o_alu_ctrl = ALU_CTRL_SLT;
                  default: o_alu_ctrl = ALU_CTRL_ADD;
               endcase
            end
         end
         default:
            o_alu_ctrl = ALU_CTRL_SUB;   // Unused class 3
      endcase
   end

endmodule

`default_nettype wire

// File: hw/stage_hold.sv
`timescale 1ns/1ns
`default_nettype none

module stage_hold
(
   input  wire                         i_clock,
   input  wire                         i_soft_reset,
   input  wire                         i_enable,
   input  wire mips_ctrl_pkg::ctrl_word_t i_ctrl,
   input  wire mips_ctrl_pkg::alu_op_e    i_alu_op,
   output mips_ctrl_pkg::ctrl_word_t      o_ctrl,
   output mips_ctrl_pkg::alu_op_e         o_alu_op
);

   import mips_ctrl_pkg::*;

   ctrl_word_t held_ctrl;   // Last decode seen with enable high

   always_ff @(posedge i_clock)
   begin
      if (!i_soft_reset)
      begin
         held_ctrl <= '0;
         o_alu_op  <= ALU_OP_MEM;
      end
      else if (i_enable)
      begin
         held_ctrl <= i_ctrl;
         o_alu_op  <= i_alu_op;   // One cycle behind the instruction
      end
   end

   // Live decode while enabled, held word while stalled
   assign o_ctrl = i_enable ? i_ctrl : held_ctrl;

endmodule

`default_nettype wire

// File: hw/mips_control.sv
`timescale 1ns/1ns
`default_nettype none

module mips_control
(
   input  wire                         i_clock,
   input  wire                         i_soft_reset,
   input  wire mips_ctrl_pkg::instr_t  i_instruction,
   input  wire                         i_enable,
   output mips_ctrl_pkg::ctrl_word_t   o_ctrl,
   output mips_ctrl_pkg::alu_op_e      o_alu_op,
   output mips_ctrl_pkg::alu_ctrl_e    o_alu_ctrl
);

   import mips_ctrl_pkg::*;

   ctrl_word_t dec_ctrl;     // Decode of the current instruction
   alu_op_e    dec_alu_op;

   ////////////////////
   // Decode
   ////////////////////

   main_decoder u_main_decoder
   (
      .i_instruction (i_instruction),
      .o_ctrl        (dec_ctrl),
      .o_alu_op      (dec_alu_op)
   );

   stage_hold u_stage_hold
   (
      .i_clock      (i_clock),
      .i_soft_reset (i_soft_reset),
      .i_enable     (i_enable),
      .i_ctrl       (dec_ctrl),
      .i_alu_op     (dec_alu_op),
      .o_ctrl       (o_ctrl),
      .o_alu_op     (o_alu_op)
   );

   ////////////////////
   // ALU code
   ////////////////////

   alu_control u_alu_control
   (
      .i_alu_op      (o_alu_op),       // Registered class
      .i_instruction (i_instruction),  // Current instruction
      .o_alu_ctrl    (o_alu_ctrl)
   );

endmodule

`default_nettype wire

// File: dv/tb_mips_control.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mips_control;

   import mips_ctrl_pkg::*;

   localparam int HALF_PERIOD   = 20;
   localparam int RESET_CYCLES  = 10;
   localparam int IDLE_CYCLES   = 3;
   localparam int RANDOM_CYCLES = 3000;
   localparam int EDGE_TIMEOUT  = 200;   // Wakeups allowed per edge wait

   localparam opcode_t LISTED_OPS [19] = '{
      OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
      OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU, OP_SB, OP_SH, OP_SW};
   localparam funct_t LISTED_FUNCTS [15] = '{
      FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_JR, FN_JALR,
      FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT};

   logic       clock;
   logic       soft_reset;
   instr_t     instruction;
   logic       enable;
   ctrl_word_t ctrl;
   alu_op_e    alu_op;
   alu_ctrl_e  alu_ctrl;

   logic [8:0] model_held;    // Last enabled decode
   logic [1:0] model_class;
   event       poll_tick;

   mips_control UUT
   (
      .i_clock       (clock),
      .i_soft_reset  (soft_reset),
      .i_instruction (instruction),
      .i_enable      (enable),
      .o_ctrl        (ctrl),
      .o_alu_op      (alu_op),
      .o_alu_ctrl    (alu_ctrl)
   );

   initial
   begin
      clock = 1'b0;
      forever #HALF_PERIOD clock = ~clock;
   end

   always #1 -> poll_tick;   // Time base for edge timeouts

   ////////////////////
   // Reference model
   ////////////////////

   // {reg_dst, reg_write, alu_src, mem_read, mem_write, mem_to_reg, mem_sel}
   function automatic logic [8:0] decode_model(input instr_t instr);
      logic [8:0] w;
      w = 9'b0;
      if (instr[31:26] == OP_SPECIAL)
      begin
         case (instr[5:0])
            FN_SLL, FN_SRL, FN_SRA: w = 9'b111000_000;
            FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU, FN_SUBU, FN_AND, FN_OR,
            FN_XOR, FN_NOR, FN_SLT, FN_JALR: w = 9'b110000_000;
            default: w = 9'b0;   // JR included
         endcase
      end
      else
      begin
         case (instr[31:26])
            OP_LB:  w = {6'b011101, 3'd5};
            OP_LH:  w = {6'b011101, 3'd6};
            OP_LW:  w = {6'b011101, 3'd7};
            OP_LWU: w = {6'b011101, 3'd3};
            OP_LBU: w = {6'b011101, 3'd1};
            OP_LHU: w = {6'b011101, 3'd2};
            OP_SB:  w = {6'b001010, 3'd1};
            OP_SH:  w = {6'b001010, 3'd2};
            OP_SW:  w = {6'b001010, 3'd3};
            OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_LUI: w = 9'b011000_000;
            OP_BEQ, OP_BNE: w = 9'b001000_000;
            OP_JAL: w = 9'b110000_000;
            default: w = 9'b0;
         endcase
      end
      return w;
   endfunction

   function automatic logic [1:0] class_model(input instr_t instr);
      logic [1:0] c;
      c = 2'd0;
      if (instr[31:26] == OP_SPECIAL)
      begin
         case (instr[5:0])
            FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU,
            FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT: c = 2'd2;
            FN_JR, FN_JALR: c = 2'd1;
            default: c = 2'd0;
         endcase
      end
      else
      begin
         case (instr[31:26])
            OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI: c = 2'd2;
            OP_BEQ, OP_BNE, OP_J, OP_JAL: c = 2'd1;
            default: c = 2'd0;   // Loads, stores, LUI, unknown
         endcase
      end
      return c;
   endfunction

   function automatic logic [3:0] alu_code_model(input logic [1:0] cls, input instr_t instr);
      logic [3:0] code;
      code = 4'd2;
      case (cls)
         2'd0: code = (instr[31:26] == OP_LUI) ? 4'd8 : 4'd2;
         2'd1: code = 4'd14;
         2'd2:
         begin
            if (instr[31:26] == OP_SPECIAL)
            begin
               case (instr[5:0])
                  FN_SLL, FN_SLLV: code = 4'd11;
                  FN_SRL, FN_SRLV: code = 4'd12;
                  FN_SRA, FN_SRAV: code = 4'd13;
                  FN_SUBU:         code = 4'd6;
                  FN_AND:          code = 4'd0;
                  FN_OR:           code = 4'd1;
                  FN_XOR:          code = 4'd9;
                  FN_NOR:          code = 4'd10;
                  FN_SLT:          code = 4'd7;
                  default:         code = 4'd2;   // ADDU and others
               endcase
            end
            else
            begin
               case (instr[31:26])
                  OP_ANDI: code = 4'd0;
                  OP_ORI:  code = 4'd1;
                  OP_XORI: code = 4'd9;
                  OP_SLTI: code = 4'd7;
                  default: code = 4'd2;
               endcase
            end
         end
         default: code = 4'd6;
      endcase
      return code;
   endfunction

   always @(posedge clock)
   begin
      if (!soft_reset)
      begin
         model_held  <= '0;
         model_class <= 2'd0;
      end
      else if (enable)
      begin
         model_held  <= decode_model(instruction);
         model_class <= class_model(instruction);
      end
   end

   ////////////////////
   // Stimulus and checks
   ////////////////////

   function automatic instr_t random_instruction();
      instr_t instr;
      int     pick;
      instr = $urandom();
      if ($urandom_range(1, 0) == 0)
      begin
         pick = $urandom_range(33, 0);
         if (pick < 19)
            instr[31:26] = LISTED_OPS[pick];
         else
         begin
            instr[31:26] = OP_SPECIAL;
            instr[5:0]   = LISTED_FUNCTS[pick - 19];
         end
      end
      return instr;
   endfunction

   task automatic fail_run(input string why);
      $display("Simulation failed");
      $fatal(1, "%s", why);
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
      fail_run({name, " does not match the model"});
   endtask

   task automatic wait_falling_edge();
      int   wakeups;
      logic was_high;
      wakeups  = 0;
      was_high = (clock === 1'b1);
      while (wakeups < EDGE_TIMEOUT)
      begin
         @(clock or poll_tick);
         if (was_high && clock === 1'b0)
            return;
         was_high = (clock === 1'b1);
         wakeups++;
      end
      fail_run("timed out waiting for a falling clock edge");
   endtask

   task automatic check_outputs();
      logic [8:0] exp_ctrl;
      logic [3:0] exp_code;
      exp_ctrl = enable ? decode_model(instruction) : model_held;
      exp_code = alu_code_model(model_class, instruction);
      assert (ctrl === exp_ctrl)
         else report_mismatch("o_ctrl", 32'(exp_ctrl), 32'(ctrl));
      assert (alu_op === model_class)
         else report_mismatch("o_alu_op", 32'(model_class), 32'(alu_op));
      assert (alu_ctrl === exp_code)
         else report_mismatch("o_alu_ctrl", 32'(exp_code), 32'(alu_ctrl));
   endtask

   task automatic run_cycle(input logic rst_n, input logic en);
      wait_falling_edge();
      soft_reset  = rst_n;
      enable      = en;
      instruction = random_instruction();
      #(HALF_PERIOD - 1);   // Just before the rising edge
      check_outputs();
   endtask

   initial
   begin
      void'($urandom(32'h05d7_bbf1));
      soft_reset  = 1'b0;
      enable      = 1'b0;
      instruction = '0;
      repeat (RESET_CYCLES)
         run_cycle(1'b0, 1'b0);
      repeat (IDLE_CYCLES)
         run_cycle(1'b1, 1'b0);   // Held word still zero
      repeat (RANDOM_CYCLES)
         run_cycle(1'b1, $urandom_range(99, 0) < 70);
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
hw/mips_ctrl_pkg.sv
hw/main_decoder.sv
hw/alu_control.sv
hw/stage_hold.sv
hw/mips_control.sv
dv/tb_mips_control.sv

// File: run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_mips_control -f sim.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
exit 0
